//--- mipsCtrlPkg.sv
package mipsCtrlPkg;

	typedef logic [5:0] opcodeT;	// instr[31:26]
	typedef logic [5:0] functT;	// instr[5:0], R-type only
	typedef logic [2:0] aluSelT;
	typedef logic [1:0] memToRegT;
	typedef logic [1:0] pcSourceT;
	typedef logic [1:0] aluSrcBT;
	typedef logic [1:0] regDstT;

	localparam opcodeT OpFunct = 6'h00;	// R-type, look at funct
	localparam opcodeT OpJ = 6'h02;
	localparam opcodeT OpBeq = 6'h04;
	localparam opcodeT OpBne = 6'h05;
	localparam opcodeT OpLui = 6'h0f;
	localparam opcodeT OpLw = 6'h23;
	localparam opcodeT OpSw = 6'h2b;

	localparam functT FnNop = 6'h00;
	localparam functT FnBreak = 6'h0d;
	localparam functT FnAdd = 6'h20;
	localparam functT FnSub = 6'h22;
	localparam functT FnAnd = 6'h24;
	localparam functT FnXor = 6'h26;

	localparam aluSelT AluNone = 3'b000;
	localparam aluSelT AluAdd = 3'b001;
	localparam aluSelT AluSub = 3'b010;
	localparam aluSelT AluAnd = 3'b011;
	localparam aluSelT AluXor = 3'b110;

	localparam memToRegT MtrAluOut = 2'b00;
	localparam memToRegT MtrMdr = 2'b01;
	localparam memToRegT MtrUpperImm = 2'b10;	// imm << 16

	localparam pcSourceT PcSrcAlu = 2'b00;	// pc + 4 straight from the ALU
	localparam pcSourceT PcSrcAluOut = 2'b01;	// branch target computed in decode
	localparam pcSourceT PcSrcJump = 2'b10;

	localparam aluSrcBT SrcBReg = 2'b00;
	localparam aluSrcBT SrcBFour = 2'b01;
	localparam aluSrcBT SrcBSignExt = 2'b10;
	localparam aluSrcBT SrcBShifted = 2'b11;	// sign-extended offset << 2

	localparam regDstT RegDstRt = 2'b00;
	localparam regDstT RegDstRd = 2'b01;

	typedef enum logic [3:0]
	{
		ClsAdd, ClsAnd, ClsSub, ClsXor, ClsBreak, ClsNop,
		ClsBeq, ClsBne, ClsLw, ClsSw, ClsLui, ClsJ
	} instrClassT;

	// order matters, stateOut shows the raw encoding
	typedef enum logic [4:0]
	{
		StReset, StFetch, StFetchWait, StFetchLatch, StDecode,
		StAluOp, StRWriteBack, StBeq, StBne, StJ, StLui, StNop, StBreak,
		StMemAddr, StStore, StLoad, StLoadWait, StLoadWriteBack
	} ctrlStateT;

endpackage

//--- instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
(
	input mipsCtrlPkg::opcodeT op,
	input mipsCtrlPkg::functT funct,	// only meaningful for OpFunct
	output mipsCtrlPkg::instrClassT instrClass
);

	import mipsCtrlPkg::*;

	always_comb
	begin
		instrClass = ClsNop;	// anything unknown behaves as a nop
		case (op)
			OpFunct:
			begin
				case (funct)
					FnAdd: instrClass = ClsAdd;
					FnAnd: instrClass = ClsAnd;
					FnSub: instrClass = ClsSub;
					FnXor: instrClass = ClsXor;
					FnBreak: instrClass = ClsBreak;
					FnNop: instrClass = ClsNop;
					default: instrClass = ClsNop;
				endcase
			end
			OpBeq: instrClass = ClsBeq;
			OpBne: instrClass = ClsBne;
			OpLw: instrClass = ClsLw;
			OpSw: instrClass = ClsSw;
			OpLui: instrClass = ClsLui;
			OpJ: instrClass = ClsJ;
			default: instrClass = ClsNop;
		endcase
	end

endmodule

//--- memWaitTimer.sv
`timescale 1ns/1ps

module memWaitTimer
#(
	parameter int MemWaitCycles = 2	// at least 1
)
(
	input logic Clk,
	input logic Reset_signal,
	input logic memStart,	// one-cycle pulse from the FSM
	output logic memDone
);

	localparam int CntW = $clog2(MemWaitCycles + 1);

	logic [CntW-1:0] count;	// cycles left, 0 when idle

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
		begin
			count <= '0;
		end
		else if (memStart)
		begin
			count <= CntW'(MemWaitCycles);	// a new start restarts the count
		end
		else if (count != '0)
		begin
			count <= count - 1'b1;
		end
	end

	// count reads 1 exactly MemWaitCycles cycles after the start pulse
	assign memDone = (count == CntW'(1));

endmodule

//--- ctrlFsm.sv
`timescale 1ns/1ps

module ctrlFsm
(
	input logic Clk,
	input logic Reset_signal,
	input mipsCtrlPkg::instrClassT instrClass,
	input logic memDone,
	output logic memStart,
	output mipsCtrlPkg::ctrlStateT state
);

	import mipsCtrlPkg::*;

	ctrlStateT nextState;

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
		begin
			state <= StReset;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			StReset: nextState = StFetch;
			StFetch: nextState = StFetchWait;
			StFetchWait:
			begin
				if (memDone)	// instruction word is on the bus
					nextState = StFetchLatch;
			end
			StFetchLatch: nextState = StDecode;
			StDecode:
			begin
				case (instrClass)
					ClsAdd, ClsAnd, ClsSub, ClsXor: nextState = StAluOp;
					ClsBeq: nextState = StBeq;
					ClsBne: nextState = StBne;
					ClsLw, ClsSw: nextState = StMemAddr;	// shared address calc
					ClsLui: nextState = StLui;
					ClsJ: nextState = StJ;
					ClsBreak: nextState = StBreak;
					default: nextState = StNop;
				endcase
			end
			StAluOp: nextState = StRWriteBack;
			StMemAddr:
			begin
				if (instrClass == ClsSw)
					nextState = StStore;
				else
					nextState = StLoad;
			end
			StLoad: nextState = StLoadWait;
			StLoadWait:
			begin
				if (memDone)
					nextState = StLoadWriteBack;
			end
			StBreak: nextState = StBreak;	// halted until reset
			StRWriteBack, StBeq, StBne, StJ, StLui, StNop, StStore, StLoadWriteBack:
			begin
				nextState = StFetch;
			end
			default: nextState = StReset;	// illegal encoding
		endcase
	end

	// each of these states lasts one cycle, so this is a single pulse
	assign memStart = (state == StFetch) || (state == StLoad);

endmodule

//--- ctrlWordGen.sv
`timescale 1ns/1ps

module ctrlWordGen
(
	input mipsCtrlPkg::ctrlStateT state,
	input mipsCtrlPkg::instrClassT instrClass,
	input logic aluZero,
	output logic pcLoad,
	output mipsCtrlPkg::pcSourceT pcSource,
	output logic wr,
	output logic irWrite,
	output logic regWrite,
	output logic regClear,
	output mipsCtrlPkg::aluSelT aluSel,
	output mipsCtrlPkg::memToRegT memToReg,
	output logic aluSrcA,
	output mipsCtrlPkg::aluSrcBT aluSrcB,
	output logic iorD,
	output mipsCtrlPkg::regDstT regDst,
	output logic abLoad,
	output logic mdrLoad,
	output logic aluOutLoad
);

	import mipsCtrlPkg::*;

	always_comb
	begin
		pcLoad = 1'b0;
		pcSource = PcSrcAlu;
		wr = 1'b0;
		irWrite = 1'b0;
		regWrite = 1'b0;
		regClear = 1'b0;
		aluSel = AluNone;
		memToReg = MtrAluOut;
		aluSrcA = 1'b0;	// pc
		aluSrcB = SrcBReg;
		iorD = 1'b0;	// instruction address
		regDst = RegDstRt;
		abLoad = 1'b0;
		mdrLoad = 1'b0;
		aluOutLoad = 1'b0;

		case (state)
			StReset: regClear = 1'b1;
			StFetchLatch:
			begin
				irWrite = 1'b1;
				mdrLoad = 1'b1;
				pcLoad = 1'b1;	// pc <= pc + 4
				aluSel = AluAdd;
				aluSrcB = SrcBFour;
			end
			StDecode:
			begin
				abLoad = 1'b1;	// register file reads into A and B
				aluOutLoad = 1'b1;	// branch target, in case it is needed
				aluSel = AluAdd;
				aluSrcB = SrcBShifted;
			end
			StAluOp:
			begin
				aluOutLoad = 1'b1;
				aluSrcA = 1'b1;
				case (instrClass)
					ClsAnd: aluSel = AluAnd;
					ClsSub: aluSel = AluSub;
					ClsXor: aluSel = AluXor;
					default: aluSel = AluAdd;
				endcase
			end
			StRWriteBack:
			begin
				regWrite = 1'b1;
				regDst = RegDstRd;
				memToReg = MtrAluOut;
			end
			StBeq, StBne:
			begin
				// A - B sets aluZero, the target waits in ALUOut
				pcLoad = (state == StBeq) ? aluZero : !aluZero;
				aluSel = AluSub;
				aluSrcA = 1'b1;
				pcSource = PcSrcAluOut;
			end
			StJ:
			begin
				pcLoad = 1'b1;
				pcSource = PcSrcJump;
			end
			StLui:
			begin
				regWrite = 1'b1;
				memToReg = MtrUpperImm;
				regDst = RegDstRt;
			end
			StMemAddr:
			begin
				aluOutLoad = 1'b1;	// A + offset
				aluSel = AluAdd;
				aluSrcA = 1'b1;
				aluSrcB = SrcBSignExt;
			end
			StStore:
			begin
				wr = 1'b1;
				iorD = 1'b1;
			end
			StLoad, StLoadWait:
			begin
				iorD = 1'b1;	// data address from ALUOut
				mdrLoad = 1'b1;
			end
			StLoadWriteBack:
			begin
				regWrite = 1'b1;
				memToReg = MtrMdr;
			end
			default:
			begin
				// fetch, fetch wait, nop and break keep the all-zero word
			end
		endcase
	end

endmodule

//--- mipsControl.sv
`timescale 1ns/1ps

module mipsControl
#(
	parameter int MemWaitCycles = 2
)
(
	input logic Clk,
	input logic Reset_signal,
	input mipsCtrlPkg::opcodeT op,
	input mipsCtrlPkg::functT funct,
	input logic aluZero,
	output mipsCtrlPkg::ctrlStateT stateOut,
	output logic pcLoad,
	output mipsCtrlPkg::pcSourceT pcSource,
	output logic wr,
	output logic irWrite,
	output logic regWrite,
	output logic regClear,
	output mipsCtrlPkg::aluSelT aluSel,
	output mipsCtrlPkg::memToRegT memToReg,
	output logic aluSrcA,
	output mipsCtrlPkg::aluSrcBT aluSrcB,
	output logic iorD,
	output mipsCtrlPkg::regDstT regDst,
	output logic abLoad,
	output logic mdrLoad,
	output logic aluOutLoad
);

	import mipsCtrlPkg::*;

	instrClassT instrClass;
	ctrlStateT state;
	logic memStart;
	logic memDone;

	instrDecoder decoder0
	(
		.op(op),
		.funct(funct),
		.instrClass(instrClass)
	);

	memWaitTimer #(.MemWaitCycles(MemWaitCycles)) memTimer0
	(
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.memStart(memStart),
		.memDone(memDone)
	);

	ctrlFsm fsm0
	(
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.instrClass(instrClass),
		.memDone(memDone),
		.memStart(memStart),
		.state(state)
	);

	ctrlWordGen wordGen0
	(
		.state(state),
		.instrClass(instrClass),
		.aluZero(aluZero),
		.pcLoad(pcLoad),
		.pcSource(pcSource),
		.wr(wr),
		.irWrite(irWrite),
		.regWrite(regWrite),
		.regClear(regClear),
		.aluSel(aluSel),
		.memToReg(memToReg),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.iorD(iorD),
		.regDst(regDst),
		.abLoad(abLoad),
		.mdrLoad(mdrLoad),
		.aluOutLoad(aluOutLoad)
	);

	assign stateOut = state;	// debug view of the FSM

endmodule

//--- ctrlMonitor.sv
`timescale 1ns/1ps

module ctrlMonitor
#(
	parameter int MemWaitCycles = 2
)
(
	input logic Clk,
	input logic Reset_signal,
	input mipsCtrlPkg::opcodeT op,
	input mipsCtrlPkg::functT funct,
	input int expLen,	// cycles, or hold cycles in StBreak for break
	input int expRegWrite,
	input int expWr,
	input int expPcLoad,
	input mipsCtrlPkg::aluSelT expAluSel,
	input mipsCtrlPkg::ctrlStateT stateOut,
	input logic pcLoad,
	input mipsCtrlPkg::pcSourceT pcSource,
	input logic wr,
	input logic irWrite,
	input logic regWrite,
	input logic regClear,
	input mipsCtrlPkg::aluSelT aluSel,
	input mipsCtrlPkg::memToRegT memToReg,
	input logic aluSrcA,
	input mipsCtrlPkg::aluSrcBT aluSrcB,
	input logic iorD,
	input mipsCtrlPkg::regDstT regDst,
	input logic abLoad,
	input logic mdrLoad,
	input logic aluOutLoad,
	output int passCount,
	output int failCount,
	output logic done
);

	import mipsCtrlPkg::*;

	int testNum;
	int errs;
	int resetErrs;
	int resetCycles;
	bit resetSeen;
	bit active;
	bit isBreak;
	int cycles, rwCnt, wrCnt, pcCnt, breakCycles;	// tallies of the running test
	int curLen, curRw, curWr, curPc;	// expectations latched at StFetch
	aluSelT curAlu;
	aluSelT aluSeen;
	pcSourceT lastPcSource;
	opcodeT curOp;
	functT curFunct;

	initial
	begin
		passCount = 0;
		failCount = 0;
		done = 1'b0;
		testNum = 0;
		resetErrs = 0;
		resetCycles = 0;
		resetSeen = 1'b0;
		active = 1'b0;
	end

	function automatic int countMismatch(input int id, input string name, input int expected,
		input int actual);
		if (expected != actual)
		begin
			$display("** Error test %0d: %s expected %h, got %h", id, name, expected, actual);
			return 1;
		end
		return 0;
	endfunction

	task automatic reportTest(input int id, input string label, input int errCount);
		if (errCount == 0)
		begin
			passCount++;
			$display("test %0d %s: ok", id, label);
		end
		else
		begin
			failCount++;
			$display("test %0d %s: %0d errors", id, label, errCount);
		end
	endtask

	task automatic closeTest();
		if (!isBreak)
			errs += countMismatch(testNum, "cycle count", curLen, cycles);
		errs += countMismatch(testNum, "regWrite count", curRw, rwCnt);
		errs += countMismatch(testNum, "wr count", curWr, wrCnt);
		errs += countMismatch(testNum, "pcLoad count", curPc, pcCnt);
		errs += countMismatch(testNum, "aluSel", curAlu, aluSeen);
		if (curOp == OpJ)
			errs += countMismatch(testNum, "pcSource", PcSrcJump, lastPcSource);
		reportTest(testNum, $sformatf("op %h funct %h", curOp, curFunct), errs);
		active = 1'b0;
	endtask

	task automatic sampleCycle();
		cycles++;
		if (regWrite)
		begin
			rwCnt++;
			if (curOp == OpLw)
				errs += countMismatch(testNum, "memToReg", MtrMdr, memToReg);
			else if (curOp == OpLui)
			begin
				errs += countMismatch(testNum, "memToReg", MtrUpperImm, memToReg);
				errs += countMismatch(testNum, "regDst", RegDstRt, regDst);
			end
			else
			begin
				errs += countMismatch(testNum, "memToReg", MtrAluOut, memToReg);
				errs += countMismatch(testNum, "regDst", RegDstRd, regDst);
			end
		end
		if (wr)
		begin
			wrCnt++;
			errs += countMismatch(testNum, "iorD", 1, iorD);	// store goes to the data address
		end
		if (pcLoad)
		begin
			pcCnt++;
			lastPcSource = pcSource;
		end
		if (irWrite)
		begin
			errs += countMismatch(testNum, "aluSrcA", 0, aluSrcA);	// pc + 4
			errs += countMismatch(testNum, "aluSrcB", SrcBFour, aluSrcB);
		end
		if (abLoad)
			errs += countMismatch(testNum, "aluSrcB", SrcBShifted, aluSrcB);
		if (stateOut == StAluOp)
		begin
			aluSeen = aluSel;
			errs += countMismatch(testNum, "aluSrcA", 1, aluSrcA);
			errs += countMismatch(testNum, "aluSrcB", SrcBReg, aluSrcB);
		end
		if (stateOut == StMemAddr)
		begin
			errs += countMismatch(testNum, "aluSrcA", 1, aluSrcA);	// base register
			errs += countMismatch(testNum, "aluSrcB", SrcBSignExt, aluSrcB);
		end
		if (isBreak && stateOut == StBreak)
		begin
			breakCycles++;
			errs += countMismatch(testNum, "irWrite", 0, irWrite);
		end
		else if (isBreak && breakCycles > 0)
		begin
			$display("test %0d: FSM left the break state before reset", testNum);
			errs++;
		end
	endtask

	always @(posedge Clk)
	begin
		if (Reset_signal)
		begin
			resetErrs += countMismatch(0, "regClear", 1, regClear);
			resetErrs += countMismatch(0, "{pcLoad,wr,irWrite,regWrite,abLoad,mdrLoad,aluOutLoad}",
				0, {pcLoad, wr, irWrite, regWrite, abLoad, mdrLoad, aluOutLoad});
		end
		else
		begin
			if (!resetSeen && stateOut == StDecode)
			begin
				resetErrs += countMismatch(0, "cycles to decode", MemWaitCycles + 3, resetCycles);
				reportTest(0, "reset", resetErrs);
				resetSeen = 1'b1;
			end
			else if (!resetSeen)
				resetCycles++;
			if (stateOut == StFetch)	// one instruction ends, the next begins
			begin
				if (active)
					closeTest();
				testNum++;
				curOp = op;
				curFunct = funct;
				curLen = expLen;
				curRw = expRegWrite;
				curWr = expWr;
				curPc = expPcLoad;
				curAlu = expAluSel;
				isBreak = (op == OpFunct) && (funct == FnBreak);
				{cycles, rwCnt, wrCnt, pcCnt, breakCycles, errs} = '0;
				aluSeen = AluNone;
				lastPcSource = PcSrcAlu;
				active = 1'b1;
			end
			if (active)
				sampleCycle();
			if (active && isBreak && breakCycles == curLen)
			begin
				closeTest();
				done = 1'b1;
			end
		end
	end

endmodule

//--- tbMipsControl.sv
`timescale 1ns/1ps

module tbMipsControl;

	import mipsCtrlPkg::*;

	localparam int MemWaitCycles = 2;
	localparam int MaxTests = 32;

	logic Clk;
	logic Reset_signal;
	opcodeT op;
	functT funct;
	logic aluZero;
	ctrlStateT stateOut;
	logic pcLoad;
	pcSourceT pcSource;
	logic wr;
	logic irWrite;
	logic regWrite;
	logic regClear;
	aluSelT aluSel;
	memToRegT memToReg;
	logic aluSrcA;
	aluSrcBT aluSrcB;
	logic iorD;
	regDstT regDst;
	logic abLoad;
	logic mdrLoad;
	logic aluOutLoad;

	int expLen, expRegWrite, expWr, expPcLoad;
	aluSelT expAluSel;
	int passCount;
	int failCount;
	logic done;

	opcodeT patOp [MaxTests];
	functT patFunct [MaxTests];
	logic patZero [MaxTests];
	int patLen [MaxTests];
	int patRw [MaxTests];
	int patWr [MaxTests];
	int patPc [MaxTests];
	aluSelT patAlu [MaxTests];
	int numTests;
	int testIdx;
	int cycleLimit;	// all pattern lengths plus slack
	int cycleCount;
	bit fileOk;

	mipsControl #(.MemWaitCycles(MemWaitCycles)) dut0 (.*);

	ctrlMonitor #(.MemWaitCycles(MemWaitCycles)) monitor0 (.*);

	initial
	begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	task automatic readPatterns();
		int fd;
		int code;
		logic [8*128-1:0] skipLine;
		fd = $fopen("ctrlPatterns.txt", "r");
		fileOk = (fd != 0);
		numTests = 0;
		cycleLimit = 20;
		if (fileOk)
		begin
			while (!$feof(fd) && numTests < MaxTests)
			begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h\n", patOp[numTests],
					patFunct[numTests], patZero[numTests], patLen[numTests], patRw[numTests],
					patWr[numTests], patPc[numTests], patAlu[numTests]);
				if (code == 8)
				begin
					cycleLimit += patLen[numTests];
					numTests++;
				end
				else
					code = $fgets(skipLine, fd);	// comment line
			end
			$fclose(fd);
		end
	endtask

	task automatic applyPattern(input int i);
		op = patOp[i];
		funct = patFunct[i];
		aluZero = patZero[i];
		expLen = patLen[i];
		expRegWrite = patRw[i];
		expWr = patWr[i];
		expPcLoad = patPc[i];
		expAluSel = patAlu[i];
	endtask

	initial
	begin
		Reset_signal = 1'b1;
		op = '0;
		funct = '0;
		aluZero = 1'b0;
		{expLen, expRegWrite, expWr, expPcLoad} = '0;
		expAluSel = AluNone;
		readPatterns();
		if (!fileOk || numTests == 0)
		begin
			$display("could not read any test from ctrlPatterns.txt");
			$display("*** FAILED ***");
			$finish;
		end
		else
		begin
			repeat (2) @(posedge Clk);
			@(negedge Clk);
			Reset_signal = 1'b0;
			for (testIdx = 0; testIdx < numTests; testIdx++)
			begin
				@(negedge Clk);
				while (stateOut != StFetch)	// previous instruction still running
					@(negedge Clk);
				applyPattern(testIdx);
			end
			while (!done)
				@(posedge Clk);
			$display("tests passed: %0d, failed: %0d", passCount, failCount);
			if (failCount == 0 && passCount == numTests + 1)
				$display("*** PASSED ***");
			else
				$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		cycleCount = 0;
		@(negedge Reset_signal);
		while (cycleCount < cycleLimit)
		begin
			@(posedge Clk);
			cycleCount++;
		end
		$display("timeout: instruction never returned to fetch");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- ctrlPatterns.txt
# op funct aluZero length regWrite wr pcLoad aluSel, all hex, length for MemWaitCycles 2
# for break the length column is the number of cycles held in StBreak
00 20 0 07 1 0 1 1
00 24 0 07 1 0 1 3
00 22 0 07 1 0 1 2
00 26 0 07 1 0 1 6
00 00 0 06 0 0 1 0
00 3f 0 06 0 0 1 0
04 00 1 06 0 0 2 0
04 00 0 06 0 0 1 0
05 00 0 06 0 0 2 0
05 00 1 06 0 0 1 0
23 00 0 0a 1 0 1 0
2b 00 0 07 0 1 1 0
02 00 0 06 0 0 2 0
0f 00 0 06 1 0 1 0
3f 00 0 06 0 0 1 0
00 0d 0 1e 0 0 1 0

//--- files.f
mipsCtrlPkg.sv
instrDecoder.sv
memWaitTimer.sv
ctrlFsm.sv
ctrlWordGen.sv
mipsControl.sv
ctrlMonitor.sv
tbMipsControl.sv
